//--- compile.f
+incdir+testbench
source/sprite_pkg.sv
source/hvsync_generator.sv
source/car_bitmap.sv
source/sprite_renderer.sv
source/sprite_video_top.sv
testbench/sprite_video_tb.sv

//--- Bender.yml
package:
  name: sprite_video

sources:
  - files:
      - source/sprite_pkg.sv
      - source/hvsync_generator.sv
      - source/car_bitmap.sv
      - source/sprite_renderer.sv
      - source/sprite_video_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/sprite_video_tb.sv

//--- testbench/sprite_ref_model.svh
`ifndef sprite_ref_model_svh
`define sprite_ref_model_svh

	// ========================================================================
	// Raster timing as seen from outside the DUT
	// ========================================================================

	localparam int line_clocks  = 309;  // 256 + 7 + 23 + 23
	localparam int frame_lines  = 262;  // 240 + 5 + 3 + 14
	localparam int visible_cols = 256;
	localparam int visible_rows = 240;
	localparam int hs_begin     = 263;  // First clock of the sync pulse
	localparam int hs_stop      = 286;  // One past the last
	localparam int vs_begin     = 245;
	localparam int vs_stop      = 248;

	// Left half of the car, bit 7 leftmost
	function automatic logic [7:0] car_row_bits(input int row);
		logic [7:0] bits;
		case (row)
			0:       bits = 8'b00000000;
			1:       bits = 8'b00001100;
			2:       bits = 8'b11001100;
			3:       bits = 8'b11111100;
			4:       bits = 8'b11101100;
			5:       bits = 8'b11100000;
			6:       bits = 8'b01100000;
			7:       bits = 8'b01110000;
			8:       bits = 8'b00110000;
			9:       bits = 8'b00110000;
			10:      bits = 8'b00110000;
			11:      bits = 8'b01101110;
			12:      bits = 8'b11101110;
			13:      bits = 8'b11111110;
			14:      bits = 8'b11101110;
			default: bits = 8'b00101110;
		endcase
		return bits;
	endfunction

	// Pixel of the 16 x 16 image, right half mirrored from the stored half
	function automatic logic sprite_pixel_lit(input int h, input int v, input int x, input int y);
		int         c;
		int         row;
		logic [7:0] bits;
		logic       lit;
		c   = h - x;
		row = v - y;
		lit = 1'b0;
		if ((h < visible_cols) && (v < visible_rows) && (c >= 0) && (c < 16)
				&& (row >= 0) && (row < 16)) begin
			bits = car_row_bits(row);
			lit  = (c < 8) ? bits[7 - c] : bits[c - 8];
		end
		return lit;
	endfunction

	function automatic logic in_hsync_window(input int h);
		return (h >= hs_begin) && (h < hs_stop);
	endfunction

	function automatic logic in_vsync_window(input int v);
		return (v >= vs_begin) && (v < vs_stop);
	endfunction

`endif

//--- testbench/sprite_video_tb.sv
`timescale 1ns/1ps

module sprite_video_tb
	import sprite_pkg::*;
();

	`include "sprite_ref_model.svh"

	localparam logic [2:0] tb_color     = 3'b101;
	localparam int         num_cases    = 6;
	localparam int         frame_cycles = line_clocks * frame_lines;  // 80958 clocks
	localparam int         cycle_limit  = (num_cases + 1) * frame_cycles + 100;

	typedef struct packed {
		sprite_pos_t pos;
		logic [15:0] lit_count;  // Expected lit pixels in one frame
	} frame_case_t;

	logic        clk25;
	logic        rst_n;
	sprite_pos_t pos;
	logic        hsync;
	logic        vsync;
	rgb_t        rgb;

	frame_case_t cases [num_cases];
	integer      seed;
	int          beam_cycle;       // Beam position index since reset
	int          clock_count = 0;
	int          lit_pixels;
	sprite_pos_t frame_pos;        // Position the current frame was latched with

	sprite_video_top #(
		.sprite_color (tb_color)
	) UUT (
		.clk25 (clk25),
		.rst_n (rst_n),
		.pos   (pos),
		.hsync (hsync),
		.vsync (vsync),
		.rgb   (rgb)
	);

	always #50 clk25 = ~clk25;  // 100 ns period

	always @(posedge clk25) begin
		clock_count = clock_count + 1;
		if (clock_count > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	end

	// ========================================================================
	// Checking helpers
	// ========================================================================

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Mismatch at time %0t: %s at hpos %0d vpos %0d, got %0h, expected %0h",
				$time, what, beam_cycle % line_clocks,
				(beam_cycle / line_clocks) % frame_lines, actual, expected);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	function automatic frame_case_t make_case(input int x, input int y, input int count);
		frame_case_t entry;
		entry.pos.x     = 9'(x);
		entry.pos.y     = 9'(y);
		entry.lit_count = 16'(count);
		return entry;
	endfunction

	task automatic load_cases();
		int rand_x;
		int rand_y;
		rand_x = $unsigned($random(seed)) % 241;  // Sprite may start up to pixel 240
		rand_y = $unsigned($random(seed)) % 225;  // and up to line 224
		cases[0] = make_case(128, 128, 118);
		cases[1] = make_case(0, 0, 118);          // Left and top edge
		cases[2] = make_case(240, 224, 118);      // Last legal corner
		cases[3] = make_case(17, 3, 118);
		cases[4] = make_case(100, 200, 118);
		cases[5] = make_case(rand_x, rand_y, 118);
	endtask

	// ========================================================================
	// Drive one beam position on the rising edge and check it on the falling one
	// ========================================================================

	task automatic step_beam(input logic drive_new, input sprite_pos_t new_pos);
		int         hpos_m;
		int         vpos_m;
		logic       lit;
		logic [2:0] exp_rgb;
		@(posedge clk25);
		hpos_m = beam_cycle % line_clocks;
		vpos_m = (beam_cycle / line_clocks) % frame_lines;
		if ((hpos_m == 0) && (vpos_m == 0)) begin
			frame_pos = pos;  // DUT takes the position on this edge
		end
		lit     = sprite_pixel_lit(hpos_m, vpos_m, frame_pos.x, frame_pos.y);
		exp_rgb = lit ? tb_color : 3'b000;
		if (drive_new) begin
			pos <= new_pos;
		end
		@(negedge clk25);
		check_value(hsync, in_hsync_window(hpos_m), "hsync");
		check_value(vsync, in_vsync_window(vpos_m), "vsync");
		check_value(rgb, exp_rgb, "rgb");
		if (rgb != 3'b000) begin
			lit_pixels = lit_pixels + 1;
		end
		beam_cycle = beam_cycle + 1;
	endtask

	// Next position is driven at a random point of a visible line
	task automatic run_frame(input int index, input sprite_pos_t next_pos);
		int change_at;
		change_at = ($unsigned($random(seed)) % visible_rows) * line_clocks
			+ $unsigned($random(seed)) % line_clocks;
		lit_pixels = 0;
		for (int k = 0; k < frame_cycles; k++) begin
			step_beam(k == change_at, next_pos);
		end
		check_value(lit_pixels, cases[index].lit_count, "lit pixel count");
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		sprite_pos_t spare_pos;
		sprite_pos_t next_pos;
		seed       = 32'h0ec91fe5;
		clk25      = 1'b0;
		rst_n      = 1'b0;
		beam_cycle = 0;
		lit_pixels = 0;
		frame_pos  = '0;
		load_cases();
		spare_pos.x = 9'($unsigned($random(seed)) % 241);  // Only reaches the frame after the run
		spare_pos.y = 9'($unsigned($random(seed)) % 225);
		pos = cases[0].pos;

		repeat (7) @(posedge clk25);
		@(negedge clk25);
		check_value(hsync, 1'b0, "hsync in reset");
		check_value(vsync, 1'b0, "vsync in reset");
		check_value(rgb, 3'b000, "rgb in reset");
		@(posedge clk25);
		rst_n <= 1'b1;  // Eighth reset cycle ends here

		for (int i = 0; i < num_cases; i++) begin
			if (i < num_cases - 1) begin
				next_pos = cases[i + 1].pos;
			end else begin
				next_pos = spare_pos;
			end
			run_frame(i, next_pos);
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- source/sprite_video_top.sv
`timescale 1ns/1ps

module sprite_video_top
	import sprite_pkg::*;
#(
	parameter logic [2:0] sprite_color = 3'b111
) (
	input  logic        clk25,
	input  logic        rst_n,
	input  sprite_pos_t pos,
	output logic        hsync,
	output logic        vsync,
	output rgb_t        rgb
);

	beam_t      beam;      // Beam position and timing flags
	logic [3:0] row;       // Sprite row address
	logic [7:0] row_bits;  // Half-image row from the ROM

	// ========================================================================
	// Beam timing
	// ========================================================================

	hvsync_generator hvsync_gen (
		.clk25 (clk25),
		.rst_n (rst_n),
		.beam  (beam)
	);

	// ========================================================================
	// Sprite drawing
	// ========================================================================

	sprite_renderer #(
		.sprite_color (sprite_color)
	) renderer (
		.clk25    (clk25),
		.rst_n    (rst_n),
		.beam     (beam),
		.pos      (pos),
		.row      (row),
		.row_bits (row_bits),
		.hsync    (hsync),
		.vsync    (vsync),
		.rgb      (rgb)
	);

	car_bitmap car (
		.row  (row),
		.bits (row_bits)
	);

endmodule

//--- source/sprite_renderer.sv
`timescale 1ns/1ps

module sprite_renderer
	import sprite_pkg::*;
#(
	parameter logic [2:0] sprite_color = 3'b111
) (
	input  logic        clk25,
	input  logic        rst_n,
	input  beam_t       beam,
	input  sprite_pos_t pos,
	output logic [3:0]  row,
	input  logic [7:0]  row_bits,
	output logic        hsync,
	output logic        vsync,
	output rgb_t        rgb
);

	localparam logic [3:0] last_col = 4'(sprite_w - 1);
	localparam logic [3:0] last_row = 4'(sprite_h - 1);
	localparam logic [3:0] half_w   = 4'(bitmap_w);

	sprite_pos_t pos_q;
	sprite_pos_t cur_pos;
	logic        v_active_q;
	logic        v_active;
	logic [3:0]  yofs_q;
	logic [3:0]  yofs;
	logic        h_active_q;
	logic        h_active;
	logic [3:0]  xofs_q;
	logic [3:0]  xofs;
	logic [2:0]  bit_sel;
	logic        pixel_on;

	// ========================================================================
	// Frame-latched position
	// ========================================================================

	always_ff @(posedge clk25) begin
		if (beam.frame_start) begin
			pos_q <= pos;
		end
	end

	// The first line of a frame sees the new value before it is latched
	assign cur_pos = beam.frame_start ? pos : pos_q;

	// ========================================================================
	// Offset counters
	// ========================================================================

	// Vertical offset, stepped on the line strobe only
	always_comb begin
		v_active = v_active_q;
		yofs     = yofs_q;
		if (beam.line_start) begin
			if (beam.vpos == cur_pos.y) begin
				v_active = 1'b1;  // Top row of the sprite
				yofs     = 4'd0;
			end else if (v_active_q && (yofs_q != last_row)) begin
				yofs = yofs_q + 4'd1;
			end else begin
				v_active = 1'b0;
				yofs     = 4'd0;
			end
		end
	end

	// Horizontal offset, one step per clock from the left border
	always_comb begin
		if (beam.hpos == cur_pos.x) begin
			h_active = 1'b1;
			xofs     = 4'd0;
		end else if (h_active_q && (xofs_q != last_col)) begin
			h_active = 1'b1;
			xofs     = xofs_q + 4'd1;
		end else begin
			h_active = 1'b0;
			xofs     = 4'd0;
		end
	end

	always_ff @(posedge clk25 or negedge rst_n) begin
		if (!rst_n) begin
			v_active_q <= 1'b0;
			yofs_q     <= 4'd0;
			h_active_q <= 1'b0;
			xofs_q     <= 4'd0;
		end else begin
			v_active_q <= v_active;
			yofs_q     <= yofs;
			h_active_q <= h_active;
			xofs_q     <= xofs;
		end
	end

	// ========================================================================
	// Mirroring and pixel output
	// ========================================================================

	assign row = yofs;  // ROM address for the current line

	// Left half reads the row from bit 7 down, right half mirrors from bit 0 up
	always_comb begin
		if (xofs < half_w) begin
			bit_sel = 3'd7 - xofs[2:0];
		end else begin
			bit_sel = xofs[2:0];
		end
	end

	assign pixel_on = beam.display_on && h_active && v_active && row_bits[bit_sel];

	always_ff @(posedge clk25 or negedge rst_n) begin
		if (!rst_n) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			rgb   <= '0;
		end else begin
			hsync <= beam.hsync;  // Delayed to match the pixel
			vsync <= beam.vsync;
			rgb   <= pixel_on ? rgb_t'(sprite_color) : rgb_t'(3'b000);
		end
	end

endmodule

//--- source/car_bitmap.sv
`timescale 1ns/1ps

module car_bitmap
	import sprite_pkg::*;
(
	input  logic [3:0] row,
	output logic [7:0] bits
);

	// Left half of the car, bit 7 is the leftmost pixel
	logic [bitmap_w-1:0] table_bits;

	always_comb begin
		case (row)
			4'd0:    table_bits = 8'b00000000;
			4'd1:    table_bits = 8'b00001100;
			4'd2:    table_bits = 8'b11001100;  // Front wheels
			4'd3:    table_bits = 8'b11111100;
			4'd4:    table_bits = 8'b11101100;
			4'd5:    table_bits = 8'b11100000;
			4'd6:    table_bits = 8'b01100000;
			4'd7:    table_bits = 8'b01110000;  // Cabin
			4'd8:    table_bits = 8'b00110000;
			4'd9:    table_bits = 8'b00110000;
			4'd10:   table_bits = 8'b00110000;
			4'd11:   table_bits = 8'b01101110;
			4'd12:   table_bits = 8'b11101110;  // Rear wheels
			4'd13:   table_bits = 8'b11111110;
			4'd14:   table_bits = 8'b11101110;
			default: table_bits = 8'b00101110;  // Row 15, rear bumper
		endcase
	end

	assign bits = table_bits;

endmodule

//--- source/hvsync_generator.sv
`timescale 1ns/1ps

module hvsync_generator
	import sprite_pkg::*;
(
	input  logic  clk25,
	input  logic  rst_n,
	output beam_t beam
);

	// Sync window bounds, start inclusive and end exclusive
	localparam logic [8:0] hs_start = h_display + h_front;
	localparam logic [8:0] hs_end   = h_display + h_front + h_sync;
	localparam logic [8:0] vs_start = v_display + v_front;
	localparam logic [8:0] vs_end   = v_display + v_front + v_sync;

	logic [8:0] h_next;
	logic [8:0] v_next;
	logic       h_wrap;
	logic       v_wrap;
	beam_t      beam_next;

	// ========================================================================
	// Beam counters
	// ========================================================================

	assign h_wrap = (beam.hpos == h_total - 9'd1);  // Last clock of the line
	assign v_wrap = (beam.vpos == v_total - 9'd1);  // Last line of the frame

	always_comb begin
		if (h_wrap) begin
			h_next = 9'd0;
		end else begin
			h_next = beam.hpos + 9'd1;
		end
	end

	always_comb begin
		if (!h_wrap) begin
			v_next = beam.vpos;  // Hold until the line ends
		end else if (v_wrap) begin
			v_next = 9'd0;
		end else begin
			v_next = beam.vpos + 9'd1;
		end
	end

	// ========================================================================
	// Flags decoded from the next position
	// ========================================================================

	// Decoding ahead of the register keeps every field of beam on the same cycle
	always_comb begin
		beam_next.hpos        = h_next;
		beam_next.vpos        = v_next;
		beam_next.hsync       = (h_next >= hs_start) && (h_next < hs_end);
		beam_next.vsync       = (v_next >= vs_start) && (v_next < vs_end);
		beam_next.display_on  = (h_next < h_display) && (v_next < v_display);
		beam_next.line_start  = (h_next == 9'd0);
		beam_next.frame_start = (h_next == 9'd0) && (v_next == 9'd0);
	end

	always_ff @(posedge clk25 or negedge rst_n) begin
		if (!rst_n) begin
			beam.hpos        <= 9'd0;
			beam.vpos        <= 9'd0;
			beam.hsync       <= 1'b0;
			beam.vsync       <= 1'b0;
			beam.display_on  <= 1'b1;  // Flags as decoded for position 0,0
			beam.line_start  <= 1'b1;
			beam.frame_start <= 1'b1;
		end else begin
			beam <= beam_next;
		end
	end

endmodule

//--- source/sprite_pkg.sv
package sprite_pkg;

	// ========================================================================
	// Raster geometry, 256 x 240 visible at clk25
	// ========================================================================

	localparam logic [8:0] h_display = 9'd256;  // Visible pixels per line
	localparam logic [8:0] h_front   = 9'd7;
	localparam logic [8:0] h_sync    = 9'd23;
	localparam logic [8:0] h_back    = 9'd23;
	localparam logic [8:0] h_total   = h_display + h_front + h_sync + h_back;  // 309 clocks

	localparam logic [8:0] v_display = 9'd240;  // Visible lines per frame
	localparam logic [8:0] v_front   = 9'd5;
	localparam logic [8:0] v_sync    = 9'd3;
	localparam logic [8:0] v_back    = 9'd14;
	localparam logic [8:0] v_total   = v_display + v_front + v_sync + v_back;  // 262 lines

	// ========================================================================
	// Sprite dimensions
	// ========================================================================

	localparam int unsigned sprite_w = 16;  // Full image after mirroring
	localparam int unsigned sprite_h = 16;
	localparam int unsigned bitmap_w = 8;   // Stored half width

	// ========================================================================
	// Bundled signals
	// ========================================================================

	typedef struct packed {
		logic [8:0] hpos;
		logic [8:0] vpos;
		logic       hsync;        // Active high
		logic       vsync;        // Active high
		logic       display_on;
		logic       line_start;   // Single cycle at hpos 0
		logic       frame_start;  // Single cycle at hpos 0, vpos 0
	} beam_t;

	typedef struct packed {
		logic [8:0] x;  // Left column
		logic [8:0] y;  // Top line
	} sprite_pos_t;

	typedef struct packed {
		logic b;
		logic g;
		logic r;
	} rgb_t;

endpackage
